// File: design/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

    // Data and address word
    typedef logic [15:0] lc3b_word;

    // Register index and condition codes
    typedef logic [2:0] lc3b_reg_idx;
    typedef logic [2:0] lc3b_nzp;

    // Opcodes of the implemented subset, LC-3b encodings
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_jmp = 4'b1100,
        op_lea = 4'b1110
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // Instruction field positions (low bit of each field)
    localparam int op_lsb       = 12;
    localparam int dr_lsb       = 9;
    localparam int sr1_lsb      = 6;
    localparam int sr2_lsb      = 0;
    localparam int imm_flag_bit = 5;

    localparam lc3b_nzp  cc_reset_value = 3'b010;
    localparam lc3b_word pc_reset_value = 16'h0000;

endpackage

// File: design/lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

    typedef enum logic [3:0] {
        s_fetch1,
        s_fetch2,
        s_fetch3,
        s_decode,
        s_add,
        s_and,
        s_not,
        s_br,
        s_br_taken,
        s_lea,
        s_jmp,
        s_calc_addr,
        s_ldr1,
        s_ldr2,
        s_str1,
        s_str2
    } lc3b_state;

    // PC source
    localparam logic [1:0] pcmux_plus2   = 2'b00;
    localparam logic [1:0] pcmux_offset9 = 2'b01;
    localparam logic [1:0] pcmux_sr1     = 2'b10;

    // ALU second operand
    localparam logic [1:0] alumux_sr2     = 2'b00;
    localparam logic [1:0] alumux_imm5    = 2'b01;
    localparam logic [1:0] alumux_offset6 = 2'b10;

    // Register write data
    localparam logic [1:0] regfilemux_alu = 2'b00;
    localparam logic [1:0] regfilemux_mdr = 2'b01;
    localparam logic [1:0] regfilemux_lea = 2'b10;

    localparam logic marmux_alu = 1'b0;
    localparam logic marmux_pc  = 1'b1;
    localparam logic mdrmux_alu = 1'b0;
    localparam logic mdrmux_mem = 1'b1;

endpackage

// File: design/lc3b_alu.sv
`timescale 1ns/1ns

module lc3b_alu (
    input  lc3b_isa_pkg::lc3b_aluop aluop,
    input  lc3b_isa_pkg::lc3b_word  a,
    input  lc3b_isa_pkg::lc3b_word  b,
    output lc3b_isa_pkg::lc3b_word  f
);

    always_comb begin
        case (aluop)
            lc3b_isa_pkg::alu_add:  f = a + b;
            lc3b_isa_pkg::alu_and:  f = a & b;
            lc3b_isa_pkg::alu_not:  f = ~a;
            // Pass a, used for the store source
            lc3b_isa_pkg::alu_pass: f = a;
            default:                f = a;
        endcase
    end

endmodule

// File: design/lc3b_regfile.sv
`timescale 1ns/1ns

module lc3b_regfile (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  lc3b_isa_pkg::lc3b_reg_idx sr1,
    input  lc3b_isa_pkg::lc3b_reg_idx sr2,
    input  lc3b_isa_pkg::lc3b_reg_idx dest,
    input  lc3b_isa_pkg::lc3b_word    in_data,
    output lc3b_isa_pkg::lc3b_word    sr1_data,
    output lc3b_isa_pkg::lc3b_word    sr2_data
);

    lc3b_isa_pkg::lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in_data;
        end
    end

    // Reads see the old value during a write cycle
    assign sr1_data = regs[sr1];
    assign sr2_data = regs[sr2];

endmodule

// File: design/lc3b_control.sv
`timescale 1ns/1ns

module lc3b_control (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lc3b_isa_pkg::lc3b_opcode opcode,
    input  logic                   inst5,
    input  logic                   branch_enable,
    input  logic                   mem_resp,
    output logic                   load_pc,
    output logic                   load_ir,
    output logic                   load_regfile,
    output logic                   load_mar,
    output logic                   load_mdr,
    output logic                   load_cc,
    output logic [1:0]             pcmux_sel,
    output logic                   storemux_sel,
    output logic [1:0]             alumux_sel,
    output logic [1:0]             regfilemux_sel,
    output logic                   marmux_sel,
    output logic                   mdrmux_sel,
    output lc3b_isa_pkg::lc3b_aluop aluop,
    output logic                   mem_read,
    output logic                   mem_write
);

    lc3b_ctrl_pkg::lc3b_state state;
    lc3b_ctrl_pkg::lc3b_state next_state;

    always_comb begin
        // Safe defaults with nothing loading
        load_pc        = 1'b0;
        load_ir        = 1'b0;
        load_regfile   = 1'b0;
        load_mar       = 1'b0;
        load_mdr       = 1'b0;
        load_cc        = 1'b0;
        pcmux_sel      = lc3b_ctrl_pkg::pcmux_plus2;
        storemux_sel   = 1'b0;
        alumux_sel     = lc3b_ctrl_pkg::alumux_sr2;
        regfilemux_sel = lc3b_ctrl_pkg::regfilemux_alu;
        marmux_sel     = lc3b_ctrl_pkg::marmux_alu;
        mdrmux_sel     = lc3b_ctrl_pkg::mdrmux_alu;
        aluop          = lc3b_isa_pkg::alu_add;
        mem_read       = 1'b0;
        mem_write      = 1'b0;

        case (state)
            lc3b_ctrl_pkg::s_fetch1: begin
                // MAR <= PC, PC <= PC + 2
                marmux_sel = lc3b_ctrl_pkg::marmux_pc;
                load_mar   = 1'b1;
                pcmux_sel  = lc3b_ctrl_pkg::pcmux_plus2;
                load_pc    = 1'b1;
            end
            lc3b_ctrl_pkg::s_fetch2, lc3b_ctrl_pkg::s_ldr1: begin
                // Held until the memory answers
                mem_read   = 1'b1;
                mdrmux_sel = lc3b_ctrl_pkg::mdrmux_mem;
                load_mdr   = 1'b1;
            end
            lc3b_ctrl_pkg::s_fetch3: begin
                load_ir = 1'b1;
            end
            lc3b_ctrl_pkg::s_add, lc3b_ctrl_pkg::s_and: begin
                alumux_sel   = inst5 ? lc3b_ctrl_pkg::alumux_imm5 : lc3b_ctrl_pkg::alumux_sr2;
                aluop        = (state == lc3b_ctrl_pkg::s_add) ? lc3b_isa_pkg::alu_add
                                                                : lc3b_isa_pkg::alu_and;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            lc3b_ctrl_pkg::s_not: begin
                aluop        = lc3b_isa_pkg::alu_not;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            lc3b_ctrl_pkg::s_br_taken: begin
                pcmux_sel = lc3b_ctrl_pkg::pcmux_offset9;
                load_pc   = 1'b1;
            end
            lc3b_ctrl_pkg::s_lea: begin
                regfilemux_sel = lc3b_ctrl_pkg::regfilemux_lea;
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end
            lc3b_ctrl_pkg::s_jmp: begin
                pcmux_sel = lc3b_ctrl_pkg::pcmux_sr1;
                load_pc   = 1'b1;
            end
            lc3b_ctrl_pkg::s_calc_addr: begin
                // MAR <= BaseR + (offset6 << 1)
                alumux_sel = lc3b_ctrl_pkg::alumux_offset6;
                aluop      = lc3b_isa_pkg::alu_add;
                marmux_sel = lc3b_ctrl_pkg::marmux_alu;
                load_mar   = 1'b1;
            end
            lc3b_ctrl_pkg::s_ldr2: begin
                regfilemux_sel = lc3b_ctrl_pkg::regfilemux_mdr;
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end
            lc3b_ctrl_pkg::s_str1: begin
                // Source register comes through SR1 port
                storemux_sel = 1'b1;
                aluop        = lc3b_isa_pkg::alu_pass;
                mdrmux_sel   = lc3b_ctrl_pkg::mdrmux_alu;
                load_mdr     = 1'b1;
            end
            lc3b_ctrl_pkg::s_str2: begin
                mem_write = 1'b1;
            end
            default: begin
                // Decode and BR test issue nothing
            end
        endcase

        // No register loads and no memory request while reset is held
        if (!rst_n) begin
            load_pc      = 1'b0;
            load_ir      = 1'b0;
            load_regfile = 1'b0;
            load_mar     = 1'b0;
            load_mdr     = 1'b0;
            load_cc      = 1'b0;
            mem_read     = 1'b0;
            mem_write    = 1'b0;
        end
    end

    always_comb begin
        next_state = state;

        case (state)
            lc3b_ctrl_pkg::s_fetch1: next_state = lc3b_ctrl_pkg::s_fetch2;
            lc3b_ctrl_pkg::s_fetch2: begin
                if (mem_resp) begin
                    next_state = lc3b_ctrl_pkg::s_fetch3;
                end
            end
            lc3b_ctrl_pkg::s_fetch3: next_state = lc3b_ctrl_pkg::s_decode;
            lc3b_ctrl_pkg::s_decode: begin
                case (opcode)
                    lc3b_isa_pkg::op_add: next_state = lc3b_ctrl_pkg::s_add;
                    lc3b_isa_pkg::op_and: next_state = lc3b_ctrl_pkg::s_and;
                    lc3b_isa_pkg::op_not: next_state = lc3b_ctrl_pkg::s_not;
                    lc3b_isa_pkg::op_br:  next_state = lc3b_ctrl_pkg::s_br;
                    lc3b_isa_pkg::op_lea: next_state = lc3b_ctrl_pkg::s_lea;
                    lc3b_isa_pkg::op_jmp: next_state = lc3b_ctrl_pkg::s_jmp;
                    lc3b_isa_pkg::op_ldr,
                    lc3b_isa_pkg::op_str: next_state = lc3b_ctrl_pkg::s_calc_addr;
                    // Unimplemented opcodes act as no-ops
                    default:              next_state = lc3b_ctrl_pkg::s_fetch1;
                endcase
            end
            lc3b_ctrl_pkg::s_br: begin
                next_state = branch_enable ? lc3b_ctrl_pkg::s_br_taken : lc3b_ctrl_pkg::s_fetch1;
            end
            lc3b_ctrl_pkg::s_calc_addr: begin
                next_state = (opcode == lc3b_isa_pkg::op_ldr) ? lc3b_ctrl_pkg::s_ldr1
                                                              : lc3b_ctrl_pkg::s_str1;
            end
            lc3b_ctrl_pkg::s_ldr1: begin
                if (mem_resp) begin
                    next_state = lc3b_ctrl_pkg::s_ldr2;
                end
            end
            lc3b_ctrl_pkg::s_str1: next_state = lc3b_ctrl_pkg::s_str2;
            lc3b_ctrl_pkg::s_str2: begin
                if (mem_resp) begin
                    next_state = lc3b_ctrl_pkg::s_fetch1;
                end
            end
            default: next_state = lc3b_ctrl_pkg::s_fetch1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= lc3b_ctrl_pkg::s_fetch1;
        end else begin
            state <= next_state;
        end
    end

endmodule

// File: design/lc3b_datapath.sv
`timescale 1ns/1ns

module lc3b_datapath (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_pc,
    input  logic                     load_ir,
    input  logic                     load_regfile,
    input  logic                     load_mar,
    input  logic                     load_mdr,
    input  logic                     load_cc,
    input  logic [1:0]               pcmux_sel,
    input  logic                     storemux_sel,
    input  logic [1:0]               alumux_sel,
    input  logic [1:0]               regfilemux_sel,
    input  logic                     marmux_sel,
    input  logic                     mdrmux_sel,
    input  lc3b_isa_pkg::lc3b_aluop   aluop,
    input  lc3b_isa_pkg::lc3b_word    mem_rdata,
    input  logic                     mem_resp,
    output lc3b_isa_pkg::lc3b_opcode  opcode,
    output logic                     inst5,
    output logic                     branch_enable,
    output lc3b_isa_pkg::lc3b_word    mem_address,
    output lc3b_isa_pkg::lc3b_word    mem_wdata
);

    lc3b_isa_pkg::lc3b_word pc;
    lc3b_isa_pkg::lc3b_word ir;
    lc3b_isa_pkg::lc3b_word mar;
    lc3b_isa_pkg::lc3b_word mdr;
    lc3b_isa_pkg::lc3b_nzp  cc;
    lc3b_isa_pkg::lc3b_nzp  cc_next;

    lc3b_isa_pkg::lc3b_reg_idx sr1_idx;
    lc3b_isa_pkg::lc3b_word    sr1_data;
    lc3b_isa_pkg::lc3b_word    sr2_data;
    lc3b_isa_pkg::lc3b_word    imm5;
    lc3b_isa_pkg::lc3b_word    offset6;
    lc3b_isa_pkg::lc3b_word    offset9;
    lc3b_isa_pkg::lc3b_word    pc_target;
    lc3b_isa_pkg::lc3b_word    alu_b;
    lc3b_isa_pkg::lc3b_word    alu_out;
    lc3b_isa_pkg::lc3b_word    pc_next;
    lc3b_isa_pkg::lc3b_word    reg_wdata;

    // Immediates, offsets are word offsets
    assign imm5    = {{11{ir[4]}}, ir[4:0]};
    assign offset6 = {{9{ir[5]}}, ir[5:0], 1'b0};
    assign offset9 = {{6{ir[8]}}, ir[8:0], 1'b0};

    // Shared by BR taken and LEA, PC already advanced
    assign pc_target = pc + offset9;

    // STR reads its source register through SR1
    assign sr1_idx = storemux_sel ? ir[lc3b_isa_pkg::dr_lsb +: 3] : ir[lc3b_isa_pkg::sr1_lsb +: 3];

    lc3b_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load_regfile),
        .sr1      (sr1_idx),
        .sr2      (ir[lc3b_isa_pkg::sr2_lsb +: 3]),
        .dest     (ir[lc3b_isa_pkg::dr_lsb +: 3]),
        .in_data  (reg_wdata),
        .sr1_data (sr1_data),
        .sr2_data (sr2_data)
    );

    always_comb begin
        case (alumux_sel)
            lc3b_ctrl_pkg::alumux_imm5:    alu_b = imm5;
            lc3b_ctrl_pkg::alumux_offset6: alu_b = offset6;
            default:                       alu_b = sr2_data;
        endcase

        case (pcmux_sel)
            lc3b_ctrl_pkg::pcmux_offset9: pc_next = pc_target;
            lc3b_ctrl_pkg::pcmux_sr1:     pc_next = sr1_data;
            default:                      pc_next = pc + 16'd2;
        endcase

        case (regfilemux_sel)
            lc3b_ctrl_pkg::regfilemux_mdr: reg_wdata = mdr;
            lc3b_ctrl_pkg::regfilemux_lea: reg_wdata = pc_target;
            default:                       reg_wdata = alu_out;
        endcase
    end

    lc3b_alu u_alu (
        .aluop (aluop),
        .a     (sr1_data),
        .b     (alu_b),
        .f     (alu_out)
    );

    // Condition codes follow the register write data
    assign cc_next = {reg_wdata[15], reg_wdata == '0, !reg_wdata[15] && (reg_wdata != '0)};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= lc3b_isa_pkg::pc_reset_value;
            cc <= lc3b_isa_pkg::cc_reset_value;
        end else begin
            if (load_pc) begin
                pc <= pc_next;
            end
            if (load_cc) begin
                cc <= cc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_ir) begin
            ir <= mdr;
        end
        if (load_mar) begin
            mar <= (marmux_sel == lc3b_ctrl_pkg::marmux_pc) ? pc : alu_out;
        end
        // A stalled read leaves MDR untouched
        if (load_mdr && mdrmux_sel == lc3b_ctrl_pkg::mdrmux_alu) begin
            mdr <= alu_out;
        end else if (load_mdr && mem_resp) begin
            mdr <= mem_rdata;
        end
    end

    assign opcode        = lc3b_isa_pkg::lc3b_opcode'(ir[lc3b_isa_pkg::op_lsb +: 4]);
    assign inst5         = ir[lc3b_isa_pkg::imm_flag_bit];
    assign branch_enable = |(ir[lc3b_isa_pkg::dr_lsb +: 3] & cc);
    assign mem_address   = mar;
    assign mem_wdata     = mdr;

endmodule

// File: design/lc3b_cpu.sv
`timescale 1ns/1ns

module lc3b_cpu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lc3b_isa_pkg::lc3b_word mem_rdata,
    input  logic                  mem_resp,
    output lc3b_isa_pkg::lc3b_word mem_address,
    output lc3b_isa_pkg::lc3b_word mem_wdata,
    output logic                  mem_read,
    output logic                  mem_write
);

    logic                     load_pc;
    logic                     load_ir;
    logic                     load_regfile;
    logic                     load_mar;
    logic                     load_mdr;
    logic                     load_cc;
    logic [1:0]               pcmux_sel;
    logic                     storemux_sel;
    logic [1:0]               alumux_sel;
    logic [1:0]               regfilemux_sel;
    logic                     marmux_sel;
    logic                     mdrmux_sel;
    lc3b_isa_pkg::lc3b_aluop  aluop;
    lc3b_isa_pkg::lc3b_opcode opcode;
    logic                     inst5;
    logic                     branch_enable;

    lc3b_control u_control (
        .clk            (clk),
        .rst_n          (rst_n),
        .opcode         (opcode),
        .inst5          (inst5),
        .branch_enable  (branch_enable),
        .mem_resp       (mem_resp),
        .load_pc        (load_pc),
        .load_ir        (load_ir),
        .load_regfile   (load_regfile),
        .load_mar       (load_mar),
        .load_mdr       (load_mdr),
        .load_cc        (load_cc),
        .pcmux_sel      (pcmux_sel),
        .storemux_sel   (storemux_sel),
        .alumux_sel     (alumux_sel),
        .regfilemux_sel (regfilemux_sel),
        .marmux_sel     (marmux_sel),
        .mdrmux_sel     (mdrmux_sel),
        .aluop          (aluop),
        .mem_read       (mem_read),
        .mem_write      (mem_write)
    );

    lc3b_datapath u_datapath (
        .clk            (clk),
        .rst_n          (rst_n),
        .load_pc        (load_pc),
        .load_ir        (load_ir),
        .load_regfile   (load_regfile),
        .load_mar       (load_mar),
        .load_mdr       (load_mdr),
        .load_cc        (load_cc),
        .pcmux_sel      (pcmux_sel),
        .storemux_sel   (storemux_sel),
        .alumux_sel     (alumux_sel),
        .regfilemux_sel (regfilemux_sel),
        .marmux_sel     (marmux_sel),
        .mdrmux_sel     (mdrmux_sel),
        .aluop          (aluop),
        .mem_rdata      (mem_rdata),
        .mem_resp       (mem_resp),
        .opcode         (opcode),
        .inst5          (inst5),
        .branch_enable  (branch_enable),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata)
    );

endmodule

// File: tests/lc3b_ref_model.svh
`ifndef LC3B_REF_MODEL_SVH
`define LC3B_REF_MODEL_SVH

// Architectural state, one instruction per model_step call
lc3b_isa_pkg::lc3b_word model_pc;
lc3b_isa_pkg::lc3b_nzp  model_cc;
lc3b_isa_pkg::lc3b_word model_regs [8];
lc3b_isa_pkg::lc3b_word model_mem [256];

task automatic model_reset();
    model_pc = 16'h0000;
    model_cc = 3'b010;
    for (int r = 0; r < 8; r++) begin
        model_regs[r] = '0;
    end
endtask

// Register write with the matching condition code update
task automatic model_write_reg(input lc3b_isa_pkg::lc3b_reg_idx dr,
                               input lc3b_isa_pkg::lc3b_word value);
    model_regs[dr] = value;
    if (value[15]) begin
        model_cc = 3'b100;
    end else if (value == '0) begin
        model_cc = 3'b010;
    end else begin
        model_cc = 3'b001;
    end
endtask

// Executes one instruction and reports the memory traffic it implies
task automatic model_step(output lc3b_isa_pkg::lc3b_word fetch_addr,
                          output logic is_load,
                          output logic is_store,
                          output lc3b_isa_pkg::lc3b_word addr,
                          output lc3b_isa_pkg::lc3b_word data);
    lc3b_isa_pkg::lc3b_word ir;
    lc3b_isa_pkg::lc3b_word base;
    lc3b_isa_pkg::lc3b_word operand;
    lc3b_isa_pkg::lc3b_word pc_offset;
    fetch_addr = model_pc;
    ir         = model_mem[model_pc[8:1]];
    model_pc   = model_pc + 16'd2;
    base       = model_regs[ir[8:6]];
    operand    = ir[5] ? lc3b_isa_pkg::lc3b_word'($signed(ir[4:0])) : model_regs[ir[2:0]];
    // Word offsets, scaled to bytes
    pc_offset  = lc3b_isa_pkg::lc3b_word'($signed(ir[8:0])) << 1;
    addr       = base + (lc3b_isa_pkg::lc3b_word'($signed(ir[5:0])) << 1);
    data       = model_regs[ir[11:9]];
    is_load    = 1'b0;
    is_store   = 1'b0;
    case (ir[15:12])
        lc3b_isa_pkg::op_add: model_write_reg(ir[11:9], base + operand);
        lc3b_isa_pkg::op_and: model_write_reg(ir[11:9], base & operand);
        lc3b_isa_pkg::op_not: model_write_reg(ir[11:9], ~base);
        lc3b_isa_pkg::op_lea: model_write_reg(ir[11:9], model_pc + pc_offset);
        lc3b_isa_pkg::op_jmp: model_pc = base;
        lc3b_isa_pkg::op_br: begin
            if ((ir[11:9] & model_cc) != 3'b000) begin
                model_pc = model_pc + pc_offset;
            end
        end
        lc3b_isa_pkg::op_ldr: begin
            is_load = 1'b1;
            model_write_reg(ir[11:9], model_mem[addr[8:1]]);
        end
        lc3b_isa_pkg::op_str: begin
            is_store = 1'b1;
            model_mem[addr[8:1]] = data;
        end
        default: begin
            // Unimplemented opcodes retire as no-ops
        end
    endcase
endtask

`endif

// File: tests/tb_lc3b_cpu.sv
`timescale 1ns/1ns

module tb_lc3b_cpu;

    localparam int num_instr = 2000;
    // Worst instruction is 6 cycles plus two accesses of 4, plus request detection
    localparam int cycle_limit = num_instr * (6 + 4 + 4 + 2) + 100;

    logic                   clk = 1'b0;
    logic                   rst_n;
    lc3b_isa_pkg::lc3b_word mem_rdata;
    logic                   mem_resp;
    lc3b_isa_pkg::lc3b_word mem_address;
    lc3b_isa_pkg::lc3b_word mem_wdata;
    logic                   mem_read;
    logic                   mem_write;

    lc3b_isa_pkg::lc3b_word    mem [256];
    lc3b_isa_pkg::lc3b_opcode  opcode_table [8] = '{
        lc3b_isa_pkg::op_br,  lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_ldr, lc3b_isa_pkg::op_str,
        lc3b_isa_pkg::op_and, lc3b_isa_pkg::op_not, lc3b_isa_pkg::op_jmp, lc3b_isa_pkg::op_lea
    };
    logic [31:0]               lfsr_state = 32'h4bebbf07;
    int                        cycle_count = 0;

    `include "lc3b_ref_model.svh"

    lc3b_cpu DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_read    (mem_read),
        .mem_write   (mem_write)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            report_failure("timed out waiting for instruction fetch");
        end
    end

    task automatic report_failure(input string text);
        $display("%s", text);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic lc3b_isa_pkg::lc3b_word random_bits(input int count);
        lc3b_isa_pkg::lc3b_word value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[14:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_fetch(input string name, input lc3b_isa_pkg::lc3b_word expected,
                               input lc3b_isa_pkg::lc3b_word actual);
        if (actual !== expected) begin
            report_failure($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_load(input string name, input lc3b_isa_pkg::lc3b_word expected,
                              input lc3b_isa_pkg::lc3b_word actual);
        if (actual !== expected) begin
            report_failure($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_store(input string name,
                               input lc3b_isa_pkg::lc3b_word exp_addr,
                               input lc3b_isa_pkg::lc3b_word exp_data,
                               input lc3b_isa_pkg::lc3b_word act_addr,
                               input lc3b_isa_pkg::lc3b_word act_data);
        if (act_addr !== exp_addr || act_data !== exp_data) begin
            report_failure($sformatf("Error: %s expected %h/%h actual %h/%h", name,
                                     exp_addr, exp_data, act_addr, act_data));
        end
    endtask

    task automatic fill_memory();
        lc3b_isa_pkg::lc3b_word sel;
        lc3b_isa_pkg::lc3b_word fields;
        for (int a = 0; a < 256; a++) begin
            sel    = random_bits(3);
            fields = random_bits(12);
            mem[a] = {opcode_table[sel[2:0]], fields[11:0]};
        end
    endtask

    // Request must stay up with the same address and data until the response
    task automatic check_held(input logic is_write, input lc3b_isa_pkg::lc3b_word addr,
                              input lc3b_isa_pkg::lc3b_word wdata);
        if (mem_read !== !is_write || mem_write !== is_write) begin
            report_failure("memory request dropped before mem_resp");
        end
        if (mem_address !== addr) begin
            report_failure("mem_address changed while a request was pending");
        end
        if (is_write && mem_wdata !== wdata) begin
            report_failure("mem_wdata changed while a write was pending");
        end
    endtask

    // Memory with 1 to 4 cycles of random latency
    task automatic serve_access(input logic is_write, output lc3b_isa_pkg::lc3b_word addr,
                                output lc3b_isa_pkg::lc3b_word wdata);
        int delay;
        do begin
            @(posedge clk);
        end while (!mem_read && !mem_write);
        if (mem_read && mem_write) begin
            report_failure("mem_read and mem_write were raised together");
        end
        if (mem_write !== is_write) begin
            report_failure(is_write ? "a read was issued where a store was expected"
                                    : "a write was issued where a read was expected");
        end
        addr  = mem_address;
        wdata = mem_wdata;
        delay = int'(random_bits(2)) + 1;
        for (int i = 1; i < delay; i++) begin
            @(posedge clk);
            check_held(is_write, addr, wdata);
        end
        mem_rdata <= mem[addr[8:1]];
        mem_resp  <= 1'b1;
        @(posedge clk);
        check_held(is_write, addr, wdata);
        mem_resp <= 1'b0;
        if (is_write) begin
            mem[addr[8:1]] = wdata;
        end
    endtask

    task automatic apply_reset();
        rst_n     <= 1'b0;
        mem_resp  <= 1'b0;
        mem_rdata <= '0;
        repeat (16) begin
            @(posedge clk);
            if (mem_read || mem_write) begin
                report_failure("memory request raised during reset");
            end
        end
        rst_n <= 1'b1;
    endtask

    initial begin
        lc3b_isa_pkg::lc3b_word exp_fetch;
        lc3b_isa_pkg::lc3b_word exp_addr;
        lc3b_isa_pkg::lc3b_word exp_data;
        lc3b_isa_pkg::lc3b_word seen_addr;
        lc3b_isa_pkg::lc3b_word seen_data;
        logic                   is_load;
        logic                   is_store;
        fill_memory();
        model_mem = mem;
        model_reset();
        apply_reset();
        for (int n = 0; n < num_instr; n++) begin
            model_step(exp_fetch, is_load, is_store, exp_addr, exp_data);
            serve_access(1'b0, seen_addr, seen_data);
            check_fetch($sformatf("fetch %0d", n), exp_fetch, seen_addr);
            if (is_load) begin
                serve_access(1'b0, seen_addr, seen_data);
                check_load($sformatf("ldr %0d", n), exp_addr, seen_addr);
            end
            if (is_store) begin
                serve_access(1'b1, seen_addr, seen_data);
                check_store($sformatf("str %0d", n), exp_addr, exp_data, seen_addr, seen_data);
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: build.f
+incdir+tests
design/lc3b_isa_pkg.sv
design/lc3b_ctrl_pkg.sv
design/lc3b_alu.sv
design/lc3b_regfile.sv
design/lc3b_control.sv
design/lc3b_datapath.sv
design/lc3b_cpu.sv
tests/tb_lc3b_cpu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_lc3b_cpu -f build.f -o tb_lc3b_cpu > sim.log 2>&1 &&
./obj_dir/tb_lc3b_cpu >> sim.log 2>&1
grep -qx '>>> PASS' sim.log && echo "simulation passed" ||
    { echo "simulation failed, see sim.log"; exit 1; }
